/* list.f */
+incdir+.
mem_pkg.sv
mem_req_if.sv
operand_fetch.sv
result_store.sv
mem_port_arbiter.sv
mem_manager.sv
tb_mem_model.sv
tb_mem_manager.sv

/* mem_manager.sv */
`timescale 1ns/1ps

module mem_manager import mem_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  cmd_valid,
  input  cmd_u  cmd_word,
  input  data_t store_data,
  output data_t cond,
  output data_t src1,
  output data_t src0,
  output logic  fetch_done,
  output logic  store_done,
  output logic  fetch_busy,
  output logic  store_busy,
  output addr_t mem_addr,
  output data_t mem_wdata,
  output logic  read_q,
  output logic  write_q,
  input  data_t mem_rdata,
  input  logic  read_dn,
  input  logic  write_dn
);

  mem_req_if fetch_req ();
  mem_req_if store_req ();

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Clients
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  operand_fetch u_fetch (
    .clk        (clk),
    .rst        (rst),
    .cmd_valid  (cmd_valid),
    .cmd_word   (cmd_word),
    .req        (fetch_req),
    .cond       (cond),
    .src1       (src1),
    .src0       (src0),
    .fetch_done (fetch_done),
    .fetch_busy (fetch_busy)
  );

  result_store u_store (
    .clk        (clk),
    .rst        (rst),
    .cmd_valid  (cmd_valid),
    .cmd_word   (cmd_word),
    .store_data (store_data),
    .req        (store_req),
    .store_done (store_done),
    .store_busy (store_busy)
  );

  // Single memory port, store engine first
  mem_port_arbiter u_arb (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd_word  (cmd_word),
    .fetch_req (fetch_req),
    .store_req (store_req),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .read_q    (read_q),
    .write_q   (write_q),
    .mem_rdata (mem_rdata),
    .read_dn   (read_dn),
    .write_dn  (write_dn)
  );

endmodule

/* mem_pkg.sv */
`include "mem_settings.svh"

package mem_pkg;

  typedef logic [`DATA_W-1:0] data_t;
  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [`REG_W-1:0]  reg_num_t;

  typedef enum logic [3:0] {
    OP_NOP      = 4'h0,
    OP_SET_BASE = 4'h1,
    OP_FETCH    = 4'h2,
    OP_STORE    = 4'h3
  } opcode_e;

  // One operand as named by the command
  typedef struct packed {
    reg_num_t   num;
    logic       ptr;    // Register holds an address
    logic [1:0] flags;  // 11 means constant one
  } operand_spec_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Two views of the command word, selected by the opcode
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    opcode_e    opcode;      // [31:28]
    logic [1:0] cond_flags;  // [27:26]
    logic [1:0] dst_flags;   // [25:24]
    logic [1:0] src0_flags;  // [23:22]
    logic [1:0] src1_flags;  // [21:20]
    logic       cond_ptr;    // [19]
    logic       dst_ptr;     // [18]
    logic       src0_ptr;    // [17]
    logic       src1_ptr;    // [16]
    reg_num_t   cond_reg;    // [15:12]
    reg_num_t   dst_reg;     // [11:8]
    reg_num_t   src0_reg;    // [7:4]
    reg_num_t   src1_reg;    // [3:0]
  } op_fields_t;

  typedef struct packed {
    opcode_e                  opcode;
    logic [`DATA_W-5-`ADDR_W:0] unused;
    addr_t                    base_addr;  // Register window start
  } base_fields_t;

  typedef union packed {
    op_fields_t   op;
    base_fields_t base;
  } cmd_u;

endpackage

/* mem_port_arbiter.sv */
`timescale 1ns/1ps

module mem_port_arbiter import mem_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       cmd_valid,
  input  cmd_u       cmd_word,
  mem_req_if.arbiter fetch_req,
  mem_req_if.arbiter store_req,
  output addr_t      mem_addr,
  output data_t      mem_wdata,
  output logic       read_q,
  output logic       write_q,
  input  data_t      mem_rdata,
  input  logic       read_dn,
  input  logic       write_dn
);

  addr_t base;
  logic  busy;
  logic  owner_store;  // Access in flight belongs to the store engine
  logic  is_read;
  logic  fetch_done_q;
  logic  store_done_q;
  data_t rdata_q;
  logic  store_any;
  logic  fetch_any;
  logic  grant;
  logic  sel_rd;
  logic  sel_rel;
  addr_t sel_addr;
  data_t sel_wdata;
  logic  mem_dn;

  assign store_any = store_req.rd | store_req.wr;
  assign fetch_any = fetch_req.rd | fetch_req.wr;

  // A client still shows its old request during its done cycle
  assign grant = !busy && !fetch_done_q && !store_done_q && (store_any || fetch_any);

  assign sel_rd    = store_any ? store_req.rd      : fetch_req.rd;
  assign sel_rel   = store_any ? store_req.reg_rel : fetch_req.reg_rel;
  assign sel_addr  = store_any ? store_req.addr    : fetch_req.addr;
  assign sel_wdata = store_any ? store_req.wdata   : fetch_req.wdata;
  assign mem_dn    = is_read ? read_dn : write_dn;

  assign fetch_req.rdata = rdata_q;
  assign store_req.rdata = rdata_q;
  assign fetch_req.done  = fetch_done_q;
  assign store_req.done  = store_done_q;

  always_ff @(posedge clk) begin
    if (grant) begin
      mem_addr  <= sel_rel ? base + addr_t'({reg_num_t'(sel_addr), 2'b00}) : sel_addr;
      mem_wdata <= sel_wdata;
    end
    if (busy && is_read && read_dn) begin
      rdata_q <= mem_rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      base         <= '0;
      busy         <= 1'b0;
      owner_store  <= 1'b0;
      is_read      <= 1'b0;
      read_q       <= 1'b0;
      write_q      <= 1'b0;
      fetch_done_q <= 1'b0;
      store_done_q <= 1'b0;
    end else begin
      read_q       <= 1'b0;
      write_q      <= 1'b0;
      fetch_done_q <= 1'b0;
      store_done_q <= 1'b0;
      if (cmd_valid && cmd_word.base.opcode == OP_SET_BASE) begin
        base <= cmd_word.base.base_addr;
      end
      if (grant) begin
        busy        <= 1'b1;
        owner_store <= store_any;
        is_read     <= sel_rd;
        read_q      <= sel_rd;
        write_q     <= !sel_rd;
      end else if (busy && mem_dn) begin
        busy         <= 1'b0;
        store_done_q <= owner_store;
        fetch_done_q <= !owner_store;
      end
    end
  end

endmodule

/* mem_req_if.sv */
`timescale 1ns/1ps

interface mem_req_if import mem_pkg::*; ();

  logic  rd;       // Held until done
  logic  wr;       // Held until done
  logic  reg_rel;  // addr is a register number
  addr_t addr;
  data_t wdata;
  data_t rdata;
  logic  done;     // One-cycle pulse

  modport client (
    output rd, wr, reg_rel, addr, wdata,
    input  rdata, done
  );

  modport arbiter (
    input  rd, wr, reg_rel, addr, wdata,
    output rdata, done
  );

endinterface

/* mem_settings.svh */
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define DATA_W 32  // Memory word and command word
`define ADDR_W 16  // Byte address on the memory port
`define REG_W  4   // Register number inside the window

`endif

/* operand_fetch.sv */
`timescale 1ns/1ps

module operand_fetch import mem_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      cmd_valid,
  input  cmd_u      cmd_word,
  mem_req_if.client req,
  output data_t     cond,
  output data_t     src1,
  output data_t     src0,
  output logic      fetch_done,
  output logic      fetch_busy
);

  localparam logic [1:0] F_IDLE = 2'd0;
  localparam logic [1:0] F_SPEC = 2'd1;  // Decide constant or memory
  localparam logic [1:0] F_REG  = 2'd2;  // Register read outstanding
  localparam logic [1:0] F_PTR  = 2'd3;  // Pointer target read outstanding

  logic [1:0]    state;
  logic [1:0]    idx;       // 0 cond, 1 src1, 2 src0
  op_fields_t    fields;
  operand_spec_t cur_spec;
  logic          accept;
  logic          last_op;
  logic          load_en;   // Current operand is complete
  data_t         load_val;

  assign accept  = cmd_valid && !fetch_busy && cmd_word.op.opcode == OP_FETCH;
  assign last_op = (idx == 2'd2);

  assign req.wr    = 1'b0;  // Read-only client
  assign req.wdata = '0;

  always_comb begin
    case (idx)
      2'd0:    cur_spec = {fields.cond_reg, fields.cond_ptr, fields.cond_flags};
      2'd1:    cur_spec = {fields.src1_reg, fields.src1_ptr, fields.src1_flags};
      default: cur_spec = {fields.src0_reg, fields.src0_ptr, fields.src0_flags};
    endcase
  end

  always_comb begin
    load_en  = 1'b0;
    load_val = req.rdata;
    if (state == F_SPEC && cur_spec.flags == 2'b11) begin
      load_en  = 1'b1;
      load_val = data_t'(1);
    end else if (state == F_REG && req.done && !cur_spec.ptr) begin
      load_en = 1'b1;
    end else if (state == F_PTR && req.done) begin
      load_en = 1'b1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Command fields and operand registers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (accept) begin
      fields <= cmd_word.op;
    end
    if (load_en) begin
      case (idx)
        2'd0:    cond <= load_val;
        2'd1:    src1 <= load_val;
        default: src0 <= load_val;
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Progress through cond, src1, src0
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= F_IDLE;
      idx         <= 2'd0;
      fetch_busy  <= 1'b0;
      fetch_done  <= 1'b0;
      req.rd      <= 1'b0;
      req.reg_rel <= 1'b0;
      req.addr    <= '0;
    end else begin
      fetch_done <= 1'b0;

      case (state)
        F_IDLE: begin
          if (accept) begin
            fetch_busy <= 1'b1;
            idx        <= 2'd0;
            state      <= F_SPEC;
          end
        end
        F_SPEC: begin
          if (cur_spec.flags != 2'b11) begin
            req.rd      <= 1'b1;
            req.reg_rel <= 1'b1;
            req.addr    <= addr_t'(cur_spec.num);
            state       <= F_REG;
          end
        end
        F_REG: begin
          if (req.done && cur_spec.ptr) begin
            req.reg_rel <= 1'b0;  // Second read goes to the returned address
            req.addr    <= addr_t'(req.rdata);
            state       <= F_PTR;
          end
        end
        default: ;
      endcase

      if (load_en) begin
        req.rd     <= 1'b0;
        idx        <= idx + 2'd1;
        state      <= last_op ? F_IDLE : F_SPEC;
        fetch_done <= last_op;
        fetch_busy <= !last_op;
      end
    end
  end

endmodule

/* result_store.sv */
`timescale 1ns/1ps

module result_store import mem_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      cmd_valid,
  input  cmd_u      cmd_word,
  input  data_t     store_data,
  mem_req_if.client req,
  output logic      store_done,
  output logic      store_busy
);

  localparam logic [1:0] S_IDLE   = 2'd0;
  localparam logic [1:0] S_ISSUE  = 2'd1;
  localparam logic [1:0] S_PTR_RD = 2'd2;  // Reading the pointer held in dst
  localparam logic [1:0] S_WR     = 2'd3;

  logic [1:0]    state;
  operand_spec_t dst_spec;
  data_t         data_q;
  logic          accept;

  assign accept    = cmd_valid && !store_busy && cmd_word.op.opcode == OP_STORE;
  assign req.wdata = data_q;

  always_ff @(posedge clk) begin
    if (accept) begin
      dst_spec <= {cmd_word.op.dst_reg, cmd_word.op.dst_ptr, cmd_word.op.dst_flags};
      data_q   <= store_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= S_IDLE;
      store_busy  <= 1'b0;
      store_done  <= 1'b0;
      req.rd      <= 1'b0;
      req.wr      <= 1'b0;
      req.reg_rel <= 1'b0;
      req.addr    <= '0;
    end else begin
      store_done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (accept) begin
            store_busy <= 1'b1;
            state      <= S_ISSUE;
          end
        end
        S_ISSUE: begin
          req.reg_rel <= 1'b1;
          req.addr    <= addr_t'(dst_spec.num);
          req.rd      <= dst_spec.ptr;
          req.wr      <= !dst_spec.ptr;
          state       <= dst_spec.ptr ? S_PTR_RD : S_WR;
        end
        S_PTR_RD: begin
          if (req.done) begin
            req.rd      <= 1'b0;
            req.wr      <= 1'b1;
            req.reg_rel <= 1'b0;
            req.addr    <= addr_t'(req.rdata);  // Write through the pointer
            state       <= S_WR;
          end
        end
        default: begin
          if (req.done) begin
            req.wr     <= 1'b0;
            store_done <= 1'b1;
            store_busy <= 1'b0;
            state      <= S_IDLE;
          end
        end
      endcase
    end
  end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the memory manager testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f list.f --top-module tb_mem_manager -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qF "*** PASSED ***" sim.log; then
  exit 0
fi
exit 1

/* tb_mem_manager.sv */
`timescale 1ns/1ps
`include "mem_settings.svh"

module tb_mem_manager import mem_pkg::*; ();

  localparam int    TIMEOUT = 200;  // Cycles per wait
  localparam addr_t BASE_A  = 16'h0100;
  localparam addr_t BASE_B  = 16'h0400;

  logic  clk;
  logic  rst;
  logic  cmd_valid;
  cmd_u  cmd_word;
  data_t store_data;
  data_t cond;
  data_t src1;
  data_t src0;
  logic  fetch_done;
  logic  store_done;
  logic  fetch_busy;
  logic  store_busy;
  addr_t mem_addr;
  data_t mem_wdata;
  logic  read_q;
  logic  write_q;
  data_t mem_rdata;
  logic  read_dn;
  logic  write_dn;
  logic  poke_en;
  addr_t poke_addr;
  data_t poke_data;
  int    errors = 0;
  int    tests = 0;

  mem_manager dut (.*);

  tb_mem_model u_mem (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Command building and memory access
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic operand_spec_t make_spec(reg_num_t num, logic ptr, logic [1:0] flags);
    return {num, ptr, flags};
  endfunction

  function automatic cmd_u fetch_cmd(operand_spec_t c, operand_spec_t s1, operand_spec_t s0);
    cmd_u w;
    w = '0;
    w.op.opcode     = OP_FETCH;
    w.op.cond_reg   = c.num;
    w.op.cond_ptr   = c.ptr;
    w.op.cond_flags = c.flags;
    w.op.src1_reg   = s1.num;
    w.op.src1_ptr   = s1.ptr;
    w.op.src1_flags = s1.flags;
    w.op.src0_reg   = s0.num;
    w.op.src0_ptr   = s0.ptr;
    w.op.src0_flags = s0.flags;
    return w;
  endfunction

  function automatic cmd_u store_cmd(operand_spec_t d);
    cmd_u w;
    w = '0;
    w.op.opcode    = OP_STORE;
    w.op.dst_reg   = d.num;
    w.op.dst_ptr   = d.ptr;
    w.op.dst_flags = d.flags;
    return w;
  endfunction

  function automatic cmd_u base_cmd(addr_t b);
    cmd_u w;
    w = '0;
    w.base.opcode    = OP_SET_BASE;
    w.base.base_addr = b;
    return w;
  endfunction

  // Register n of the window lives at base + 4n
  function automatic addr_t reg_addr(addr_t base, reg_num_t n);
    return base + addr_t'(n) * addr_t'(4);
  endfunction

  function automatic data_t peek(addr_t a);
    return u_mem.words[a[`ADDR_W-1:2]];
  endfunction

  task automatic poke(input addr_t a, input data_t d);
    @(posedge clk);
    poke_en   <= 1'b1;
    poke_addr <= a;
    poke_data <= d;
    @(posedge clk);
    poke_en <= 1'b0;
  endtask

  task automatic send_cmd(input cmd_u c, input data_t d);
    @(posedge clk);
    cmd_valid  <= 1'b1;
    cmd_word   <= c;
    store_data <= d;
    @(posedge clk);
    cmd_valid <= 1'b0;
  endtask

  task automatic wait_done(input logic want_fetch, input logic want_store);
    logic got_f;
    logic got_s;
    int   n;
    got_f = !want_fetch;
    got_s = !want_store;
    for (n = 0; n < TIMEOUT && !(got_f && got_s); n++) begin
      @(negedge clk);
      if (fetch_done) begin
        check_bit("fetch_busy", fetch_busy, 1'b0);  // Falls with the done pulse
      end else if (!got_f) begin
        check_bit("fetch_busy", fetch_busy, 1'b1);
      end
      if (store_done) begin
        check_bit("store_busy", store_busy, 1'b0);
      end else if (!got_s) begin
        check_bit("store_busy", store_busy, 1'b1);
      end
      got_f |= fetch_done;
      got_s |= store_done;
    end
    if (!(got_f && got_s)) begin
      $display("timeout at %0t: done pulse missing after %0d cycles", $time, TIMEOUT);
      errors++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Compare tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic check_word(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error at %0t: %s = %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int e0);
    tests++;
    if (errors == e0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d failing checks", name, errors - e0);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic test_direct_fetch();
    int e0;
    int r0;
    e0 = errors;
    send_cmd(base_cmd(BASE_A), '0);
    poke(reg_addr(BASE_A, 4'd1), 32'h1111_0001);
    poke(reg_addr(BASE_A, 4'd2), 32'h2222_0002);
    poke(reg_addr(BASE_A, 4'd3), 32'h3333_0003);
    r0 = u_mem.rd_count;
    send_cmd(fetch_cmd(make_spec(4'd1, 1'b0, 2'b00), make_spec(4'd2, 1'b0, 2'b00),
                       make_spec(4'd3, 1'b0, 2'b00)), '0);
    wait_done(1'b1, 1'b0);
    check_word("cond", cond, 32'h1111_0001);
    check_word("src1", src1, 32'h2222_0002);
    check_word("src0", src0, 32'h3333_0003);
    check_count("reads", u_mem.rd_count - r0, 3);
    report_test("direct fetch", e0);
  endtask

  task automatic test_immediate();
    int e0;
    int r0;
    e0 = errors;
    poke(reg_addr(BASE_A, 4'd5), 32'h5555_0005);
    r0 = u_mem.rd_count;
    send_cmd(fetch_cmd(make_spec(4'd1, 1'b0, 2'b11), make_spec(4'd5, 1'b0, 2'b00),
                       make_spec(4'd3, 1'b0, 2'b11)), '0);
    wait_done(1'b1, 1'b0);
    check_word("cond", cond, 32'd1);  // Constant one without an access
    check_word("src1", src1, 32'h5555_0005);
    check_word("src0", src0, 32'd1);
    check_count("reads", u_mem.rd_count - r0, 1);
    report_test("immediate operands", e0);
  endtask

  task automatic test_pointer_fetch();
    int e0;
    int r0;
    e0 = errors;
    poke(reg_addr(BASE_A, 4'd6), 32'h0000_2000);
    poke(reg_addr(BASE_A, 4'd7), 32'h0000_2004);
    poke(reg_addr(BASE_A, 4'd8), 32'h0000_2008);
    poke(16'h2000, 32'hAAAA_0006);
    poke(16'h2004, 32'hBBBB_0007);
    poke(16'h2008, 32'hCCCC_0008);
    r0 = u_mem.rd_count;
    send_cmd(fetch_cmd(make_spec(4'd6, 1'b1, 2'b00), make_spec(4'd7, 1'b1, 2'b00),
                       make_spec(4'd8, 1'b1, 2'b00)), '0);
    wait_done(1'b1, 1'b0);
    check_word("cond", cond, 32'hAAAA_0006);
    check_word("src1", src1, 32'hBBBB_0007);
    check_word("src0", src0, 32'hCCCC_0008);
    check_count("reads", u_mem.rd_count - r0, 6);
    report_test("pointer fetch", e0);
  endtask

  task automatic test_store();
    int e0;
    int r0;
    int w0;
    e0 = errors;
    r0 = u_mem.rd_count;
    w0 = u_mem.wr_count;
    send_cmd(store_cmd(make_spec(4'd9, 1'b0, 2'b00)), 32'hDEAD_0009);
    wait_done(1'b0, 1'b1);
    check_word("dst word", peek(reg_addr(BASE_A, 4'd9)), 32'hDEAD_0009);
    check_addr("last write address", u_mem.last_wr_addr, reg_addr(BASE_A, 4'd9));
    check_count("reads", u_mem.rd_count - r0, 0);
    check_count("writes", u_mem.wr_count - w0, 1);
    poke(reg_addr(BASE_A, 4'd10), 32'h0000_3000);
    r0 = u_mem.rd_count;
    w0 = u_mem.wr_count;
    send_cmd(store_cmd(make_spec(4'd10, 1'b1, 2'b00)), 32'hBEEF_0010);
    wait_done(1'b0, 1'b1);
    check_word("pointer target", peek(16'h3000), 32'hBEEF_0010);
    check_word("pointer register", peek(reg_addr(BASE_A, 4'd10)), 32'h0000_3000);
    check_addr("last write address", u_mem.last_wr_addr, 16'h3000);
    check_count("reads", u_mem.rd_count - r0, 1);
    check_count("writes", u_mem.wr_count - w0, 1);
    report_test("store", e0);
  endtask

  task automatic test_overlap();
    int e0;
    e0 = errors;
    @(posedge clk);
    cmd_valid  <= 1'b1;
    cmd_word   <= store_cmd(make_spec(4'd11, 1'b0, 2'b00));
    store_data <= 32'h5A5A_0011;
    @(posedge clk);  // FETCH right behind the STORE
    cmd_word <= fetch_cmd(make_spec(4'd1, 1'b0, 2'b00), make_spec(4'd2, 1'b0, 2'b00),
                          make_spec(4'd3, 1'b0, 2'b00));
    @(posedge clk);
    cmd_valid <= 1'b0;
    wait_done(1'b1, 1'b1);
    check_word("dst word", peek(reg_addr(BASE_A, 4'd11)), 32'h5A5A_0011);
    check_word("cond", cond, 32'h1111_0001);
    check_word("src1", src1, 32'h2222_0002);
    check_word("src0", src0, 32'h3333_0003);
    if (u_mem.overlap) begin
      $display("memory saw a strobe while another access was still open");
      errors++;
    end
    report_test("overlap", e0);
  endtask

  task automatic test_base_change();
    int e0;
    e0 = errors;
    send_cmd(base_cmd(BASE_B), '0);
    poke(reg_addr(BASE_B, 4'd1), 32'h4444_0101);
    poke(reg_addr(BASE_B, 4'd2), 32'h4444_0202);
    poke(reg_addr(BASE_B, 4'd3), 32'h4444_0303);
    send_cmd(fetch_cmd(make_spec(4'd1, 1'b0, 2'b00), make_spec(4'd2, 1'b0, 2'b00),
                       make_spec(4'd3, 1'b0, 2'b00)), '0);
    wait_done(1'b1, 1'b0);
    check_word("cond", cond, 32'h4444_0101);
    check_word("src1", src1, 32'h4444_0202);
    check_word("src0", src0, 32'h4444_0303);
    report_test("base change", e0);
  endtask

  initial begin
    rst        = 1'b1;
    cmd_valid  = 1'b0;
    cmd_word   = '0;
    store_data = '0;
    poke_en    = 1'b0;
    poke_addr  = '0;
    poke_data  = '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    test_direct_fetch();
    test_immediate();
    test_pointer_fetch();
    test_store();
    test_overlap();
    test_base_change();
    $display("tests run %0d, failing checks %0d", tests, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* tb_mem_model.sv */
`timescale 1ns/1ps
`include "mem_settings.svh"

module tb_mem_model import mem_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  addr_t mem_addr,
  input  data_t mem_wdata,
  input  logic  read_q,
  input  logic  write_q,
  output data_t mem_rdata,
  output logic  read_dn,
  output logic  write_dn,
  input  logic  poke_en,    // Preload port, used only while the port is idle
  input  addr_t poke_addr,
  input  data_t poke_data
);

  localparam int WORDS = 1 << (`ADDR_W - 2);

  data_t words [WORDS];
  int    seed = 54364;
  int    rd_count = 0;
  int    wr_count = 0;
  logic  overlap = 1'b0;  // Strobe seen while an access was still open
  addr_t last_wr_addr;
  logic  pending;
  logic  pend_rd;
  addr_t pend_addr;
  data_t pend_data;
  int    delay_left;

  // Power-up content, a different word at every address
  function automatic data_t fill_word(int i);
    logic [`ADDR_W-3:0] w;
    w = i[`ADDR_W-3:0];
    return {2'b10, w, 2'b01, ~w};
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      pending   <= 1'b0;
      read_dn   <= 1'b0;
      write_dn  <= 1'b0;
      mem_rdata <= '0;
      for (int i = 0; i < WORDS; i++) begin
        words[i] <= fill_word(i);
      end
    end else begin
      read_dn  <= 1'b0;
      write_dn <= 1'b0;
      if (poke_en) begin
        words[poke_addr[`ADDR_W-1:2]] <= poke_data;
      end

      // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
      // Accept a strobe, answer after 1 to 4 cycles
      // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
      if (read_q || write_q) begin
        if (pending || (read_q && write_q)) begin
          overlap <= 1'b1;
        end
        if (read_q) begin
          rd_count <= rd_count + 1;
        end
        if (write_q) begin
          wr_count <= wr_count + 1;
        end
        pending    <= 1'b1;
        pend_rd    <= read_q;
        pend_addr  <= mem_addr;
        pend_data  <= mem_wdata;
        delay_left <= 1 + ($unsigned($random(seed)) % 4);
      end else if (pending) begin
        if (delay_left > 1) begin
          delay_left <= delay_left - 1;
        end else begin
          pending <= 1'b0;
          if (pend_rd) begin
            mem_rdata <= words[pend_addr[`ADDR_W-1:2]];
            read_dn   <= 1'b1;
          end else begin
            words[pend_addr[`ADDR_W-1:2]] <= pend_data;
            last_wr_addr <= pend_addr;
            write_dn     <= 1'b1;
          end
        end
      end
    end
  end

endmodule
